/* hdl/dma_read_pkg.sv */
package dma_read_pkg;

    // ----------------------------------------------------------------------
    // bus widths
    // ----------------------------------------------------------------------

    // byte address on the AXI side
    localparam int ADDR_W    = 32;

    // one 32-bit word per beat
    localparam int DATA_W    = 32;

    // log2 of bytes per beat, matches arsize
    localparam int DATA_SIZE = 2;

    // AXI4 arlen field
    localparam int LEN_W     = 8;

    // request beat count, minus one
    localparam int REQ_LEN_W = 16;

    // ----------------------------------------------------------------------
    // scalar types
    // ----------------------------------------------------------------------

    typedef logic [ADDR_W-1:0]           addr_t;
    typedef logic [ADDR_W-DATA_SIZE-1:0] word_addr_t;
    typedef logic [LEN_W-1:0]            len_t;
    typedef logic [REQ_LEN_W-1:0]        req_len_t;

    // ----------------------------------------------------------------------
    // transfer records
    // ----------------------------------------------------------------------

    // read request as it enters the core
    typedef struct packed {
        addr_t    addr;
        req_len_t len;
        len_t     max_len;
    } req_t;

    // one AXI read burst, last marks the final burst of a request
    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  last;
    } burst_t;

    // data beat on the output stream
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;
    } rbeat_t;

endpackage

/* hdl/dma_fifo.sv */
module dma_fifo #(
    parameter int  PTR_W     = 2,
    parameter type payload_t = logic
) (
    input  logic     i_aclk,
    input  logic     i_rst,

    input  payload_t i_data,
    input  logic     i_valid,
    output logic     o_ready,

    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    localparam int DEPTH = 2 ** PTR_W;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    // top bit of count only set when all entries are used
    assign o_ready = !count[PTR_W];
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

    assign wr_en = i_valid && o_ready;
    assign rd_en = o_valid && i_ready;

    always_ff @(posedge i_aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a producer held off while full keeps its word until it goes in
    a_no_write_when_full: assert property (
        @(posedge i_aclk) disable iff (i_rst)
        i_valid && !o_ready |=> i_valid && $stable(i_data)
    ) else $error("dma_fifo: word offered while full was not held");

endmodule

/* hdl/burst_gen.sv */
module burst_gen #(
    parameter int ALIGN = 12
) (
    input  logic                 i_aclk,
    input  logic                 i_rst,

    input  dma_read_pkg::req_t   i_req,
    input  logic                 i_req_valid,
    output logic                 o_req_ready,

    output dma_read_pkg::burst_t o_burst,
    output logic                 o_valid,
    input  logic                 i_ready
);

    // word offset bits inside one boundary window
    localparam int OFS_W = ALIGN - dma_read_pkg::DATA_SIZE;

    logic                     busy;
    logic                     load;
    logic                     take;
    dma_read_pkg::word_addr_t cur_addr;
    dma_read_pkg::req_len_t   remain;
    dma_read_pkg::len_t       max_len;
    logic [OFS_W-1:0]         bnd_left;
    dma_read_pkg::req_len_t   cur_len;

    // ----------------------------------------------------------------------
    // burst length select
    // ----------------------------------------------------------------------

    // words left before the boundary, minus one
    assign bnd_left = ~cur_addr[OFS_W-1:0];

    always_comb begin
        cur_len = remain;
        if (dma_read_pkg::req_len_t'(max_len) < cur_len) begin
            cur_len = dma_read_pkg::req_len_t'(max_len);
        end
        if (dma_read_pkg::req_len_t'(bnd_left) < cur_len) begin
            cur_len = dma_read_pkg::req_len_t'(bnd_left);
        end
    end

    assign o_burst.addr = {cur_addr, {dma_read_pkg::DATA_SIZE{1'b0}}};
    // never above max_len, so it fits arlen
    assign o_burst.len  = dma_read_pkg::len_t'(cur_len);
    assign o_burst.last = (remain == cur_len);

    assign o_valid     = busy;
    assign o_req_ready = !busy;

    assign load = !busy && i_req_valid;
    assign take = o_valid && i_ready;

    // ----------------------------------------------------------------------
    // request state
    // ----------------------------------------------------------------------

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (take && o_burst.last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (load) begin
            cur_addr <= i_req.addr[dma_read_pkg::ADDR_W-1:dma_read_pkg::DATA_SIZE];
            remain   <= i_req.len;
            max_len  <= i_req.max_len;
        end else if (take) begin
            cur_addr <= cur_addr + dma_read_pkg::word_addr_t'(cur_len) + 1'b1;
            // wraps after the last burst, reloaded before next use
            remain   <= remain - cur_len - 1'b1;
        end
    end

endmodule

/* hdl/ar_issue.sv */
module ar_issue #(
    parameter int RDATA_PTR_W = 6
) (
    input  logic                 i_aclk,
    input  logic                 i_rst,

    input  dma_read_pkg::burst_t i_burst,
    input  logic                 i_valid,
    output logic                 o_ready,

    input  logic                 i_credit,

    output dma_read_pkg::addr_t  o_araddr,
    output dma_read_pkg::len_t   o_arlen,
    output logic                 o_arvalid,
    input  logic                 i_arready,

    output logic                 o_rcmd_last,
    output logic                 o_rcmd_valid,
    input  logic                 i_rcmd_ready
);

    localparam int DEPTH = 2 ** RDATA_PTR_W;
    localparam int CRD_W = RDATA_PTR_W + 1;

    logic [CRD_W-1:0]              credit;
    logic [dma_read_pkg::LEN_W:0]  need;
    logic                          credit_ok;
    logic                          ar_free;
    logic                          take;

    // ----------------------------------------------------------------------
    // credit gate
    // ----------------------------------------------------------------------

    // beats in this burst
    assign need      = {1'b0, i_burst.len} + 1'b1;
    assign credit_ok = (credit >= need);

    // register frees up in the same cycle it hands off
    assign ar_free = !o_arvalid || i_arready;

    // fork to the AR register and the command queue together
    assign o_rcmd_last  = i_burst.last;
    assign o_rcmd_valid = i_valid && credit_ok && ar_free;
    assign o_ready      = credit_ok && ar_free && i_rcmd_ready;

    assign take = i_valid && o_ready;

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            credit <= CRD_W'(DEPTH);
        end else begin
            credit <= credit - (take ? CRD_W'(need) : '0) + CRD_W'(i_credit);
        end
    end

    // ----------------------------------------------------------------------
    // AR channel register
    // ----------------------------------------------------------------------

    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            o_arvalid <= 1'b0;
        end else if (take) begin
            o_arvalid <= 1'b1;
        end else if (i_arready) begin
            o_arvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (take) begin
            o_araddr <= i_burst.addr;
            o_arlen  <= i_burst.len;
        end
    end

    // a returned beat implies one was reserved and not yet given back
    a_credit_bound: assert property (
        @(posedge i_aclk) disable iff (i_rst)
        i_credit |-> credit < DEPTH
    ) else $error("ar_issue: credit returned with the data FIFO empty of reservations");

endmodule

/* hdl/rdata_path.sv */
module rdata_path #(
    parameter int RCMD_PTR_W  = 3,
    parameter int RDATA_PTR_W = 6
) (
    input  logic                              i_aclk,
    input  logic                              i_rst,

    input  logic                              i_rcmd_last,
    input  logic                              i_rcmd_valid,
    output logic                              o_rcmd_ready,

    input  logic [dma_read_pkg::DATA_W-1:0]   i_rdata_axi,
    input  logic                              i_rlast,
    input  logic                              i_rvalid,
    output logic                              o_rready,

    output dma_read_pkg::rbeat_t              o_rdata,
    output logic                              o_rdata_valid,
    input  logic                              i_rdata_ready,

    output logic                              o_credit
);

    logic                 cmd_last;
    logic                 cmd_valid;
    logic                 cmd_pop;
    logic                 r_acc;
    logic                 data_ready;
    dma_read_pkg::rbeat_t wr_beat;

    // ----------------------------------------------------------------------
    // read command queue, one flag per outstanding burst
    // ----------------------------------------------------------------------

    dma_fifo #(
        .PTR_W     (RCMD_PTR_W),
        .payload_t (logic)
    ) i_rcmd_fifo (
        .i_aclk  (i_aclk),
        .i_rst   (i_rst),
        .i_data  (i_rcmd_last),
        .i_valid (i_rcmd_valid),
        .o_ready (o_rcmd_ready),
        .o_data  (cmd_last),
        .o_valid (cmd_valid),
        .i_ready (cmd_pop)
    );

    assign o_rready = cmd_valid;
    assign r_acc    = i_rvalid && o_rready;
    assign cmd_pop  = r_acc && i_rlast;

    // ----------------------------------------------------------------------
    // read data FIFO
    // ----------------------------------------------------------------------

    // request end is the rlast of a burst flagged last
    assign wr_beat.data = i_rdata_axi;
    assign wr_beat.last = i_rlast && cmd_last;

    dma_fifo #(
        .PTR_W     (RDATA_PTR_W),
        .payload_t (dma_read_pkg::rbeat_t)
    ) i_rdata_fifo (
        .i_aclk  (i_aclk),
        .i_rst   (i_rst),
        .i_data  (wr_beat),
        .i_valid (r_acc),
        .o_ready (data_ready),
        .o_data  (o_rdata),
        .o_valid (o_rdata_valid),
        .i_ready (i_rdata_ready)
    );

    // one credit back per delivered beat
    always_ff @(posedge i_aclk) begin
        if (i_rst) begin
            o_credit <= 1'b0;
        end else begin
            o_credit <= o_rdata_valid && i_rdata_ready;
        end
    end

    // room was reserved by the credit counter when the burst went out
    a_no_beat_when_full: assert property (
        @(posedge i_aclk) disable iff (i_rst)
        r_acc |-> data_ready
    ) else $error("rdata_path: R beat accepted with the data FIFO full");

endmodule

/* hdl/dma_read_top.sv */
module dma_read_top #(
    parameter int ALIGN       = 12,
    parameter int REQ_PTR_W   = 2,
    parameter int RCMD_PTR_W  = 3,
    parameter int RDATA_PTR_W = 6
) (
    input  logic                              i_aclk,
    input  logic                              i_rst,

    input  dma_read_pkg::req_t                i_req,
    input  logic                              i_req_valid,
    output logic                              o_req_ready,

    output dma_read_pkg::addr_t               o_araddr,
    output dma_read_pkg::len_t                o_arlen,
    output logic                              o_arvalid,
    input  logic                              i_arready,

    input  logic [dma_read_pkg::DATA_W-1:0]   i_rdata_axi,
    input  logic                              i_rlast,
    input  logic                              i_rvalid,
    output logic                              o_rready,

    output dma_read_pkg::rbeat_t              o_rdata,
    output logic                              o_rdata_valid,
    input  logic                              i_rdata_ready
);

    dma_read_pkg::req_t   req_q;
    logic                 req_q_valid;
    logic                 req_q_ready;
    dma_read_pkg::burst_t burst;
    logic                 burst_valid;
    logic                 burst_ready;
    logic                 rcmd_last;
    logic                 rcmd_valid;
    logic                 rcmd_ready;
    logic                 credit;

    // ----------------------------------------------------------------------
    // request queue and burst split
    // ----------------------------------------------------------------------

    dma_fifo #(
        .PTR_W     (REQ_PTR_W),
        .payload_t (dma_read_pkg::req_t)
    ) i_req_fifo (
        .i_aclk  (i_aclk),
        .i_rst   (i_rst),
        .i_data  (i_req),
        .i_valid (i_req_valid),
        .o_ready (o_req_ready),
        .o_data  (req_q),
        .o_valid (req_q_valid),
        .i_ready (req_q_ready)
    );

    burst_gen #(
        .ALIGN (ALIGN)
    ) i_burst_gen (
        .i_aclk      (i_aclk),
        .i_rst       (i_rst),
        .i_req       (req_q),
        .i_req_valid (req_q_valid),
        .o_req_ready (req_q_ready),
        .o_burst     (burst),
        .o_valid     (burst_valid),
        .i_ready     (burst_ready)
    );

    // ----------------------------------------------------------------------
    // AR issue and read data
    // ----------------------------------------------------------------------

    ar_issue #(
        .RDATA_PTR_W (RDATA_PTR_W)
    ) i_ar_issue (
        .i_aclk       (i_aclk),
        .i_rst        (i_rst),
        .i_burst      (burst),
        .i_valid      (burst_valid),
        .o_ready      (burst_ready),
        .i_credit     (credit),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_rcmd_last  (rcmd_last),
        .o_rcmd_valid (rcmd_valid),
        .i_rcmd_ready (rcmd_ready)
    );

    rdata_path #(
        .RCMD_PTR_W  (RCMD_PTR_W),
        .RDATA_PTR_W (RDATA_PTR_W)
    ) i_rdata_path (
        .i_aclk        (i_aclk),
        .i_rst         (i_rst),
        .i_rcmd_last   (rcmd_last),
        .i_rcmd_valid  (rcmd_valid),
        .o_rcmd_ready  (rcmd_ready),
        .i_rdata_axi   (i_rdata_axi),
        .i_rlast       (i_rlast),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .i_rdata_ready (i_rdata_ready),
        .o_credit      (credit)
    );

endmodule

/* tb/axi_rd_slave.sv */
module axi_rd_slave (
    input  logic                            i_aclk,
    input  logic                            i_rst,

    input  dma_read_pkg::addr_t             i_araddr,
    input  dma_read_pkg::len_t              i_arlen,
    input  logic                            i_arvalid,
    output logic                            o_arready,

    output logic [dma_read_pkg::DATA_W-1:0] o_rdata,
    output logic                            o_rlast,
    output logic                            o_rvalid,
    input  logic                            i_rready
);

    localparam int DRIVE_DLY = 10;

    dma_read_pkg::addr_t ar_addr_q [$];
    dma_read_pkg::len_t  ar_len_q [$];
    int unsigned         beat;
    logic                r_fire;

    initial begin
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rlast   = 1'b0;
        o_rdata   = '0;
        beat      = 0;
    end

    // sampled mid-cycle, values hold through the next rising edge
    always @(negedge i_aclk) begin
        r_fire = o_rvalid && i_rready;
        if (!i_rst && i_arvalid && o_arready) begin
            ar_addr_q.push_back(i_araddr);
            ar_len_q.push_back(i_arlen);
        end
    end

    // ------------------------------------------------------------------
    // AR stalls and R beats
    // ------------------------------------------------------------------

    always @(posedge i_aclk) begin
        #DRIVE_DLY;
        if (i_rst) begin
            o_arready = 1'b0;
            o_rvalid  = 1'b0;
            o_rlast   = 1'b0;
            beat      = 0;
        end else begin
            o_arready = ($urandom % 4) != 0;
            if (r_fire) begin
                o_rvalid = 1'b0;
                if (o_rlast) begin
                    void'(ar_addr_q.pop_front());
                    void'(ar_len_q.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            // data is the beat's own byte address
            if (!o_rvalid && ar_addr_q.size() != 0 && ($urandom % 4) != 0) begin
                o_rvalid = 1'b1;
                o_rdata  = ar_addr_q[0] + (beat << dma_read_pkg::DATA_SIZE);
                o_rlast  = (beat == ar_len_q[0]);
            end
        end
    end

endmodule

/* tb/dma_read_tb.sv */
module dma_read_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 16;
    localparam int DRIVE_DLY   = 10;
    localparam int ALIGN       = 12;
    localparam int RDATA_PTR_W = 6;
    localparam int GOLD_DEPTH  = 64;
    localparam int LONG_STALL  = 400;
    localparam int DRAIN       = 20;

    logic                            i_aclk;
    logic                            i_rst;
    dma_read_pkg::req_t              i_req;
    logic                            i_req_valid;
    logic                            o_req_ready;
    dma_read_pkg::addr_t             o_araddr;
    dma_read_pkg::len_t              o_arlen;
    logic                            o_arvalid;
    logic                            i_arready;
    logic [dma_read_pkg::DATA_W-1:0] i_rdata_axi;
    logic                            i_rlast;
    logic                            i_rvalid;
    logic                            o_rready;
    dma_read_pkg::rbeat_t            o_rdata;
    logic                            o_rdata_valid;
    logic                            i_rdata_ready;

    // kind, address, len, max_len
    logic [63:0]                     golden [GOLD_DEPTH];
    dma_read_pkg::req_t              req_list [$];
    dma_read_pkg::addr_t             exp_araddr_q [$];
    dma_read_pkg::len_t              exp_arlen_q [$];
    logic [dma_read_pkg::DATA_W-1:0] exp_data_q [$];
    logic                            exp_last_q [$];

    int          err_cnt;
    int          check_cnt;
    int          total_beats;
    int          issued;
    int          delivered;
    int unsigned stall_cnt;
    logic        long_done;

    dma_read_top #(
        .ALIGN       (ALIGN),
        .REQ_PTR_W   (2),
        .RCMD_PTR_W  (3),
        .RDATA_PTR_W (RDATA_PTR_W)
    ) i_dma_read_top (
        .i_aclk        (i_aclk),
        .i_rst         (i_rst),
        .i_req         (i_req),
        .i_req_valid   (i_req_valid),
        .o_req_ready   (o_req_ready),
        .o_araddr      (o_araddr),
        .o_arlen       (o_arlen),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata_axi   (i_rdata_axi),
        .i_rlast       (i_rlast),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready),
        .o_rdata       (o_rdata),
        .o_rdata_valid (o_rdata_valid),
        .i_rdata_ready (i_rdata_ready)
    );

    axi_rd_slave i_axi_rd_slave (
        .i_aclk    (i_aclk),
        .i_rst     (i_rst),
        .i_araddr  (o_araddr),
        .i_arlen   (o_arlen),
        .i_arvalid (o_arvalid),
        .o_arready (i_arready),
        .o_rdata   (i_rdata_axi),
        .o_rlast   (i_rlast),
        .o_rvalid  (i_rvalid),
        .i_rready  (o_rready)
    );

    always #(CLK_PERIOD / 2) i_aclk = ~i_aclk;

    // ------------------------------------------------------------------
    // error reporting
    // ------------------------------------------------------------------

    function automatic void report_mismatch(string sig, logic [63:0] exp_val,
                                            logic [63:0] got_val);
        err_cnt++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, sig, exp_val, got_val);
    endfunction

    function automatic void report_error(string msg);
        err_cnt++;
        $display("ERROR at t=%0t: %s", $time, msg);
    endfunction

    // ------------------------------------------------------------------
    // golden file and expected stream
    // ------------------------------------------------------------------

    task automatic load_golden();
        dma_read_pkg::req_t req;
        for (int i = 0; i < GOLD_DEPTH; i++) begin
            golden[i] = '0;
        end
        $readmemh("tb/dma_read_golden.txt", golden);
        for (int i = 0; i < GOLD_DEPTH; i++) begin
            if (golden[i][63:56] == 8'h01) begin
                req.addr    = golden[i][55:24];
                req.len     = golden[i][23:8];
                req.max_len = golden[i][7:0];
                req_list.push_back(req);
                total_beats += int'(req.len) + 1;
                // beat k reads addr + 4k, last only on the final beat
                for (int k = 0; k <= int'(req.len); k++) begin
                    exp_data_q.push_back(req.addr + (k << dma_read_pkg::DATA_SIZE));
                    exp_last_q.push_back(k == int'(req.len));
                end
            end else if (golden[i][63:56] == 8'h02) begin
                exp_araddr_q.push_back(golden[i][55:24]);
                exp_arlen_q.push_back(golden[i][15:8]);
            end
        end
    endtask

    task automatic push_req(input dma_read_pkg::req_t req);
        i_req       = req;
        i_req_valid = 1'b1;
        @(negedge i_aclk);
        while (!o_req_ready) begin
            @(negedge i_aclk);
        end
        @(posedge i_aclk);
        #DRIVE_DLY;
        i_req_valid = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    task automatic check_reset_state();
        assert (o_arvalid == 1'b0) else report_mismatch("o_arvalid", 0, o_arvalid);
        assert (o_rready == 1'b0) else report_mismatch("o_rready", 0, o_rready);
        assert (o_rdata_valid == 1'b0) else report_mismatch("o_rdata_valid", 0, o_rdata_valid);
        assert (o_req_ready == 1'b1) else report_mismatch("o_req_ready", 1, o_req_ready);
        check_cnt += 4;
    endtask

    task automatic check_ar_transfer();
        int end_word;
        check_cnt++;
        assert (exp_araddr_q.size() != 0) else report_error("AR transfer with no golden burst left");
        if (exp_araddr_q.size() != 0) begin
            assert (o_araddr == exp_araddr_q[0])
            else report_mismatch("o_araddr", exp_araddr_q[0], o_araddr);
            assert (o_arlen == exp_arlen_q[0])
            else report_mismatch("o_arlen", exp_arlen_q[0], o_arlen);
            void'(exp_araddr_q.pop_front());
            void'(exp_arlen_q.pop_front());
        end
        // word offset inside the window plus beat count
        end_word = int'(o_araddr[ALIGN-1:dma_read_pkg::DATA_SIZE]) + int'(o_arlen) + 1;
        assert (end_word <= 2 ** (ALIGN - dma_read_pkg::DATA_SIZE))
        else report_error($sformatf("AR at %h len %0d crosses a 4 KB boundary",
                                    o_araddr, o_arlen));
        issued += int'(o_arlen) + 1;
    endtask

    task automatic check_out_beat();
        check_cnt++;
        delivered++;
        assert (exp_data_q.size() != 0) else report_error("output beat beyond the expected stream");
        if (exp_data_q.size() != 0) begin
            assert (o_rdata.data == exp_data_q[0])
            else report_mismatch("o_rdata.data", exp_data_q[0], o_rdata.data);
            assert (o_rdata.last == exp_last_q[0])
            else report_mismatch("o_rdata.last", exp_last_q[0], o_rdata.last);
            void'(exp_data_q.pop_front());
            void'(exp_last_q.pop_front());
        end
    endtask

    always @(negedge i_aclk) begin
        if (i_rst === 1'b0) begin
            if (o_arvalid && i_arready) begin
                check_ar_transfer();
            end
            if (o_rdata_valid && i_rdata_ready) begin
                check_out_beat();
            end
            assert (issued - delivered <= 2 ** RDATA_PTR_W)
            else report_error($sformatf("%0d beats outstanding", issued - delivered));
        end
    end

    // ------------------------------------------------------------------
    // output back-pressure
    // ------------------------------------------------------------------

    always @(posedge i_aclk) begin
        #DRIVE_DLY;
        if (i_rst) begin
            i_rdata_ready = 1'b0;
        end else begin
            // one long hold-off as the 64-beat burst goes out, short random ones elsewhere
            if (!long_done && delivered >= 33) begin
                stall_cnt = LONG_STALL;
                long_done = 1'b1;
            end else if (stall_cnt == 0 && ($urandom % 16) == 0) begin
                stall_cnt = 1 + $urandom % 6;
            end
            if (stall_cnt != 0) begin
                i_rdata_ready = 1'b0;
                stall_cnt--;
            end else begin
                i_rdata_ready = ($urandom % 4) != 0;
            end
        end
    end

    task automatic watchdog();
        repeat (total_beats * 20 + 2000) @(posedge i_aclk);
        $display("timeout: %0d of %0d beats delivered, checks: %0d, errors: %0d",
                 delivered, total_beats, check_cnt, err_cnt);
        $display("Simulation failed");
        $finish;
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(32'h3a41488a));
        i_aclk        = 1'b0;
        i_rst         = 1'b1;
        i_req         = '0;
        i_req_valid   = 1'b0;
        i_rdata_ready = 1'b0;
        err_cnt       = 0;
        check_cnt     = 0;
        total_beats   = 0;
        issued        = 0;
        delivered     = 0;
        stall_cnt     = 0;
        long_done     = 1'b0;
        load_golden();
        fork
            watchdog();
        join_none
        repeat (RST_CYCLES) @(posedge i_aclk);
        #DRIVE_DLY;
        i_rst = 1'b0;
        @(negedge i_aclk);
        check_reset_state();
        @(posedge i_aclk);
        #DRIVE_DLY;
        foreach (req_list[i]) begin
            push_req(req_list[i]);
        end
        wait (delivered >= total_beats);
        // catch stray AR or data after the last beat
        repeat (DRAIN) @(posedge i_aclk);
        assert (exp_araddr_q.size() == 0)
        else report_error($sformatf("%0d golden bursts never issued", exp_araddr_q.size()));
        assert (exp_data_q.size() == 0)
        else report_error($sformatf("%0d expected beats never delivered", exp_data_q.size()));
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb/dma_read_golden.txt */
// kind_addr_len_maxlen, 16 hex digits per line
// 01 request (addr, beats-1, max burst-1), 02 expected AR (araddr, arlen, 00)
01_00001000_0013_07
02_00001000_0007_00
02_00001020_0007_00
02_00001040_0003_00
// crosses 0x3000
01_00002ff0_000b_0f
02_00002ff0_0003_00
02_00003000_0007_00
// single beat
01_00010000_0000_0f
02_00010000_0000_00
// full 64-beat burst needs every credit
01_00020100_0045_3f
02_00020100_003f_00
02_00020200_0005_00
// first burst ends right at 0x5000
01_00004f80_002f_1f
02_00004f80_001f_00
02_00005000_000f_00

/* dma_read.f */
hdl/dma_read_pkg.sv
hdl/dma_fifo.sv
hdl/burst_gen.sv
hdl/ar_issue.sv
hdl/rdata_path.sv
hdl/dma_read_top.sv
tb/axi_rd_slave.sv
tb/dma_read_tb.sv

/* Bender.yml */
package:
  name: dma_read

sources:
  - hdl/dma_read_pkg.sv
  - hdl/dma_fifo.sv
  - hdl/burst_gen.sv
  - hdl/ar_issue.sv
  - hdl/rdata_path.sv
  - hdl/dma_read_top.sv
  - target: test
    files:
      - tb/axi_rd_slave.sv
      - tb/dma_read_tb.sv
